// File: compile.f
+incdir+logic
logic/datapath_pkg.sv
logic/op_fifo.sv
logic/regfile.sv
logic/scoreboard_issue.sv
logic/scalar_alu_unit.sv
logic/writeback_arbiter.sv
logic/sc_datapath.sv
testbench/sc_datapath_tb.sv

// File: logic/datapath_defines.svh
// datapath sizes for the scalar issue and execute slice
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// register data width
`define DATA_W 32

// scalar register file
`define NUM_REGS 16
`define REG_ADDR_W 4

// number of identical alu lanes
`define NUM_ALU 3

// width of a lane index
`define LANE_W 2

// result queue depth per lane, also its credit count
`define ALU_CREDITS 2

// operation queue depth, also the input credit count
`define OP_Q_DEPTH 4

`endif

// File: logic/datapath_pkg.sv
// shared types for the scalar datapath: alu opcodes, decoded and issued ops, results
`include "datapath_defines.svh"

package datapath_pkg;

    // alu operations, shifts take the low 5 bits of b
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7
    } alu_op_e;

    // decoded op from the source, imm is already sign extended
    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic                    use_imm;
        logic [`DATA_W-1:0]      imm;
    } decoded_op_t;

    // op handed to a lane, operands already read
    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`DATA_W-1:0]      a;
        logic [`DATA_W-1:0]      b;
    } lane_op_t;

    // one result for writeback
    typedef struct packed {
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`DATA_W-1:0]      data;
    } wb_t;

endpackage

// File: logic/op_fifo.sv
// op_fifo: synchronous circular buffer carrying any packed payload type
`timescale 1ns/10ps

module op_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

    // storage, no reset needed
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge CLK) disable iff (!nrst) push |-> !full);
    a_no_underflow: assert property (@(posedge CLK) disable iff (!nrst) pop |-> not_empty);

endmodule

// File: logic/regfile.sv
// regfile: scalar registers, two combinational reads and one writeback port
`timescale 1ns/10ps
`include "datapath_defines.svh"

module regfile (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`DATA_W-1:0]     rdat1,
    output logic [`DATA_W-1:0]     rdat2,
    input  logic                   wb_valid,
    input  datapath_pkg::wb_t      wb
);
    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // reads see the old value during a write cycle
    assign rdat1 = regs[rs1];
    assign rdat2 = regs[rs2];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// File: logic/sc_datapath.sv
// sc_datapath: op queue, scoreboard, alu lanes, writeback arbiter and register file
`timescale 1ns/10ps
`include "datapath_defines.svh"

module sc_datapath (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic                       op_valid,
    input  datapath_pkg::decoded_op_t  op,
    output logic                       op_credit,
    output logic                       wb_valid,
    output datapath_pkg::wb_t          wb
);
    import datapath_pkg::*;

    decoded_op_t             q_head;
    logic                    q_not_empty;
    logic                    q_pop;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`DATA_W-1:0]      rdat1;
    logic [`DATA_W-1:0]      rdat2;
    logic [`NUM_ALU-1:0]     issue_valid;
    lane_op_t                issue_op;
    logic [`NUM_ALU-1:0]     credit_return;
    logic [`NUM_ALU-1:0]     lane_pop;
    logic [`NUM_ALU-1:0]     lane_result_valid;
    wb_t                     lane_result [`NUM_ALU];

    // input credits mirror the queue depth, no full flag needed
    op_fifo #(.payload_t(decoded_op_t), .DEPTH(`OP_Q_DEPTH)) op_queue_i (
        .CLK, .nrst,
        .push(op_valid), .push_data(op), .pop(q_pop),
        .head(q_head), .not_empty(q_not_empty), .full()
    );

    // freed queue slot goes back to the source one cycle later
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            op_credit <= 1'b0;
        end else begin
            op_credit <= q_pop;
        end
    end

    scoreboard_issue scoreboard_i (
        .CLK, .nrst,
        .head(q_head), .head_valid(q_not_empty), .pop(q_pop),
        .rs1, .rs2, .rdat1, .rdat2,
        .issue_valid, .issue_op, .credit_return,
        .wb_valid, .wb_rd(wb.rd)
    );

    regfile regfile_i (.CLK, .nrst, .rs1, .rs2, .rdat1, .rdat2, .wb_valid, .wb);

    for (genvar g = 0; g < `NUM_ALU; g++) begin : g_lane
        scalar_alu_unit alu_i (
            .CLK, .nrst,
            .issue_valid(issue_valid[g]), .issue_op,
            .pop(lane_pop[g]),
            .result(lane_result[g]), .result_valid(lane_result_valid[g])
        );
    end

    writeback_arbiter wb_arb_i (
        .CLK, .nrst,
        .result_valid(lane_result_valid), .result(lane_result), .pop(lane_pop),
        .credit_return, .wb_valid, .wb
    );

endmodule

// File: logic/scalar_alu_unit.sv
// scalar_alu_unit: two stage alu lane feeding its own result queue
`timescale 1ns/10ps
`include "datapath_defines.svh"

module scalar_alu_unit (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    issue_valid,
    input  datapath_pkg::lane_op_t  issue_op,
    input  logic                    pop,
    output datapath_pkg::wb_t       result,
    output logic                    result_valid
);
    import datapath_pkg::*;

    logic               s1_valid;
    lane_op_t           s1_op;
    logic               s2_valid;
    wb_t                s2_res;
    logic [`DATA_W-1:0] alu_out;
    logic               q_full;

    always_comb begin
        case (s1_op.alu_op)
            ALU_ADD: alu_out = s1_op.a + s1_op.b;
            ALU_SUB: alu_out = s1_op.a - s1_op.b;
            ALU_AND: alu_out = s1_op.a & s1_op.b;
            ALU_OR:  alu_out = s1_op.a | s1_op.b;
            ALU_XOR: alu_out = s1_op.a ^ s1_op.b;
            ALU_SLL: alu_out = s1_op.a << s1_op.b[4:0];
            ALU_SRL: alu_out = s1_op.a >> s1_op.b[4:0];
            ALU_SLT: alu_out = {{(`DATA_W-1){1'b0}}, $signed(s1_op.a) < $signed(s1_op.b)};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
        end
    end

    // operand and result payload
    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            s1_op <= issue_op;
        end
        if (s1_valid) begin
            s2_res.rd   <= s1_op.rd;
            s2_res.data <= alu_out;
        end
    end

    op_fifo #(.payload_t(wb_t), .DEPTH(`ALU_CREDITS)) result_q_i (
        .CLK, .nrst,
        .push(s2_valid), .push_data(s2_res), .pop,
        .head(result), .not_empty(result_valid), .full(q_full)
    );

    // lane credit guarantees a free slot two cycles after issue
    a_room_at_push: assert property (@(posedge CLK) disable iff (!nrst)
        issue_valid |-> ##2 !q_full);

endmodule

// File: logic/scoreboard_issue.sv
// scoreboard_issue: pending bitmap, hazard check and credit based issue to alu lanes
`timescale 1ns/10ps
`include "datapath_defines.svh"

module scoreboard_issue (
    input  logic                        CLK,
    input  logic                        nrst,
    input  datapath_pkg::decoded_op_t   head,
    input  logic                        head_valid,
    output logic                        pop,
    output logic [`REG_ADDR_W-1:0]      rs1,
    output logic [`REG_ADDR_W-1:0]      rs2,
    input  logic [`DATA_W-1:0]          rdat1,
    input  logic [`DATA_W-1:0]          rdat2,
    output logic [`NUM_ALU-1:0]         issue_valid,
    output datapath_pkg::lane_op_t      issue_op,
    input  logic [`NUM_ALU-1:0]         credit_return,
    input  logic                        wb_valid,
    input  logic [`REG_ADDR_W-1:0]      wb_rd
);
    localparam int CRED_W = $clog2(`ALU_CREDITS + 1);

    logic [`NUM_REGS-1:0]             pending;
    logic [`NUM_REGS-1:0]             pend_set;
    logic [`NUM_REGS-1:0]             pend_clr;
    logic [`NUM_ALU-1:0][CRED_W-1:0]  credit;
    logic [`NUM_ALU-1:0]              lane_sel;
    logic                             hazard;
    logic                             can_issue;

    // source operands go straight to the register file
    assign rs1 = head.rs1;
    assign rs2 = head.rs2;

    // raw on rs1/rs2 and waw on rd, no bypass from the writeback cycle
    assign hazard = pending[head.rs1]
                  | (!head.use_imm && pending[head.rs2])
                  | pending[head.rd];

    // lowest lane with a free credit
    always_comb begin
        logic found;
        found    = 1'b0;
        lane_sel = '0;
        for (int i = 0; i < `NUM_ALU; i++) begin
            if (!found && credit[i] != '0) begin
                found       = 1'b1;
                lane_sel[i] = 1'b1;
            end
        end
    end

    assign can_issue   = head_valid && !hazard && (lane_sel != '0);
    assign pop         = can_issue;
    assign issue_valid = can_issue ? lane_sel : '0;

    always_comb begin
        issue_op.alu_op = head.alu_op;
        issue_op.rd     = head.rd;
        issue_op.a      = rdat1;
        issue_op.b      = head.use_imm ? head.imm : rdat2;
    end

    always_comb begin
        pend_set = '0;
        pend_clr = '0;
        if (can_issue) begin
            pend_set[head.rd] = 1'b1;
        end
        if (wb_valid) begin
            pend_clr[wb_rd] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pending <= '0;
            for (int i = 0; i < `NUM_ALU; i++) begin
                credit[i] <= CRED_W'(`ALU_CREDITS);
            end
        end else begin
            pending <= (pending & ~pend_clr) | pend_set;
            for (int i = 0; i < `NUM_ALU; i++) begin
                case ({issue_valid[i], credit_return[i]})
                    2'b10:   credit[i] <= credit[i] - 1'b1;
                    2'b01:   credit[i] <= credit[i] + 1'b1;
                    default: credit[i] <= credit[i];
                endcase
            end
        end
    end

    for (genvar g = 0; g < `NUM_ALU; g++) begin : g_credit_chk
        // a returned credit must belong to an op that was issued earlier
        a_no_excess: assert property (@(posedge CLK) disable iff (!nrst)
            credit_return[g] |-> (credit[g] < CRED_W'(`ALU_CREDITS)) || issue_valid[g]);
        // an underflow wraps to a value above the credit count
        a_no_negative: assert property (@(posedge CLK) disable iff (!nrst)
            credit[g] <= CRED_W'(`ALU_CREDITS));
    end

    a_one_lane: assert property (@(posedge CLK) disable iff (!nrst) $onehot0(issue_valid));

endmodule

// File: logic/writeback_arbiter.sv
// writeback_arbiter: round robin drain of lane results into the register file
`timescale 1ns/10ps
`include "datapath_defines.svh"

module writeback_arbiter (
    input  logic                 CLK,
    input  logic                 nrst,
    input  logic [`NUM_ALU-1:0]  result_valid,
    input  datapath_pkg::wb_t    result [`NUM_ALU],
    output logic [`NUM_ALU-1:0]  pop,
    output logic [`NUM_ALU-1:0]  credit_return,
    output logic                 wb_valid,
    output datapath_pkg::wb_t    wb
);
    logic [`LANE_W-1:0] rr_ptr;
    logic [`LANE_W-1:0] grant;

    // first non-empty lane at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        idx   = 0;
        found = 1'b0;
        grant = '0;
        pop   = '0;
        for (int k = 0; k < `NUM_ALU; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= `NUM_ALU) begin
                idx = idx - `NUM_ALU;
            end
            if (!found && result_valid[idx]) begin
                found    = 1'b1;
                grant    = idx[`LANE_W-1:0];
                pop[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            rr_ptr        <= '0;
            wb_valid      <= 1'b0;
            credit_return <= '0;
        end else begin
            wb_valid      <= (pop != '0);
            credit_return <= pop;
            if (pop != '0) begin
                // next search starts past the winner
                rr_ptr <= (grant == `LANE_W'(`NUM_ALU - 1)) ? '0 : grant + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (pop != '0) begin
            wb <= result[grant];
        end
    end

    a_pop_onehot: assert property (@(posedge CLK) disable iff (!nrst) $onehot0(pop));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the scalar datapath testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sc_datapath_tb \
    -f compile.f \
    --Mdir obj_dir -o sc_datapath_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/sc_datapath_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: testbench/sc_datapath_tb.sv
// testbench for the scalar datapath, with credit driven stimulus, a reference model and result checks
`timescale 1ns/10ps
`include "datapath_defines.svh"

module sc_datapath_tb;
    import datapath_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_DIRECTED = 36;
    localparam int NUM_RANDOM   = 64;
    localparam int TOTAL_OPS    = NUM_DIRECTED + NUM_RANDOM;

    // initial register contents, includes negative values and an oversized shift
    localparam logic [`DATA_W-1:0] LOAD_VALS [8] = '{
        32'h1234_5678, 32'hffff_fff0, 32'd35, 32'h8000_0001,
        32'd7, 32'h0f0f_0f0f, 32'hffff_ffff, 32'h7fff_ffff
    };

    logic        CLK;
    logic        nrst;
    logic        op_valid;
    decoded_op_t op;
    logic        op_credit;
    logic        wb_valid;
    wb_t         wb;

    // program order model and expected results per destination register
    logic [`DATA_W-1:0] ref_regs [`NUM_REGS];
    wb_t                exp_q [`NUM_REGS][$];

    int credits     = `OP_Q_DEPTH;
    int outstanding = 0;
    int wb_errors   = 0;
    int ctrl_errors = 0;

    sc_datapath sc_datapath_i (
        .CLK, .nrst, .op_valid, .op, .op_credit, .wb_valid, .wb
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    function automatic decoded_op_t make_op(input int aop, input int rd, input int rs1,
                                            input int rs2, input bit use_imm,
                                            input logic [`DATA_W-1:0] imm);
        decoded_op_t o;
        o.alu_op  = alu_op_e'(aop[3:0]);
        o.rd      = rd[`REG_ADDR_W-1:0];
        o.rs1     = rs1[`REG_ADDR_W-1:0];
        o.rs2     = rs2[`REG_ADDR_W-1:0];
        o.use_imm = use_imm;
        o.imm     = imm;
        return o;
    endfunction

    // applies one op to the model registers and returns the expected writeback
    function automatic wb_t ref_exec(input decoded_op_t o);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] r;
        wb_t                res;
        a = ref_regs[o.rs1];
        b = o.use_imm ? o.imm : ref_regs[o.rs2];
        case (o.alu_op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        ref_regs[o.rd] = r;
        res.rd   = o.rd;
        res.data = r;
        return res;
    endfunction

    task automatic check_wb(input wb_t got, input wb_t want);
        if (got !== want) begin
            $display("error at %0t ns: writeback r%0d = %h, expected r%0d = %h",
                     $time, got.rd, got.data, want.rd, want.data);
            wb_errors++;
        end
    endtask

    task automatic check_credit(input int got, input int want, input string what);
        if (got != want) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            ctrl_errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
            ctrl_errors++;
        end
    endtask

    // called 10 ns after a rising edge, returns at the same point of a later cycle
    task automatic send_op(input decoded_op_t o);
        exp_q[o.rd].push_back(ref_exec(o));
        outstanding++;
        while (credits == 0) begin
            @(posedge CLK);
            #DRIVE_DLY;
        end
        op_valid = 1'b1;
        op       = o;
        credits--;
        @(posedge CLK);
        #DRIVE_DLY;
        op_valid = 1'b0;
    endtask

    // a returned input credit is counted in the middle of its cycle
    initial begin
        forever begin
            @(negedge CLK);
            if (nrst && op_credit) begin
                credits++;
            end
        end
    end

    // every writeback counts, so an extra one leaves another queue unmatched
    initial begin
        wb_t want;
        forever begin
            @(negedge CLK);
            if (nrst && wb_valid) begin
                if (exp_q[wb.rd].size() == 0) begin
                    $display("error at %0t ns: extra writeback to r%0d with %h",
                             $time, wb.rd, wb.data);
                    wb_errors++;
                end else begin
                    want = exp_q[wb.rd].pop_front();
                    check_wb(wb, want);
                end
                outstanding--;
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 40 + RESET_CYCLES) @(posedge CLK);
        $display("timeout: %0d writebacks still missing when the time limit ran out",
                 outstanding);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [`DATA_W-1:0] imm_val;
        void'($urandom(32'h5f10_d2f6));
        nrst     = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_flag(op_credit, 1'b0, "op_credit during reset");
            check_flag(wb_valid, 1'b0, "wb_valid during reset");
        end
        @(posedge CLK);
        #DRIVE_DLY;
        nrst = 1'b1;
        repeat (2) begin
            @(negedge CLK);
            check_flag(op_credit, 1'b0, "op_credit after reset");
            check_flag(wb_valid, 1'b0, "wb_valid after reset");
        end
        @(posedge CLK);
        #DRIVE_DLY;

        for (int i = 0; i < 8; i++) begin
            send_op(make_op(ALU_ADD, i + 1, 0, 0, 1'b1, LOAD_VALS[i]));
        end

        // every opcode, register form then immediate form
        for (int k = 0; k < 8; k++) begin
            imm_val = (k % 2 == 0) ? 32'(k * 9 + 33) : -32'(k * 5);
            send_op(make_op(k, 9 + (k % 4), 1 + k, 1 + ((k + 2) % 8), 1'b0, '0));
            send_op(make_op(k, 13 + (k % 3), 8 - k, 0, 1'b1, imm_val));
        end

        // raw chain through r10..r12
        send_op(make_op(ALU_ADD, 10, 1, 2, 1'b0, '0));
        send_op(make_op(ALU_SUB, 11, 10, 3, 1'b0, '0));
        send_op(make_op(ALU_XOR, 12, 11, 10, 1'b0, '0));
        send_op(make_op(ALU_SLL, 10, 12, 0, 1'b1, 32'd4));
        send_op(make_op(ALU_SLT, 11, 2, 10, 1'b0, '0));
        send_op(make_op(ALU_OR, 12, 11, 0, 1'b1, 32'h0000_0100));

        // waw on r14, then a reader of the last value
        for (int k = 1; k <= 5; k++) begin
            send_op(make_op(ALU_ADD, 14, 0, 0, 1'b1, 32'(100 * k)));
        end
        send_op(make_op(ALU_ADD, 15, 14, 14, 1'b0, '0));

        // dense burst, limited only by input credits
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_op(make_op($urandom_range(7, 0), $urandom_range(7, 0),
                            $urandom_range(15, 0), $urandom_range(15, 0),
                            $urandom_range(1, 0) == 1, $urandom));
        end

        while (outstanding > 0) begin
            @(posedge CLK);
        end
        repeat (10) @(posedge CLK);
        check_credit(credits, `OP_Q_DEPTH, "final input credit balance");
        for (int r = 0; r < `NUM_REGS; r++) begin
            if (exp_q[r].size() != 0) begin
                $display("r%0d never received %0d expected writebacks", r, exp_q[r].size());
                ctrl_errors++;
            end
        end

        $display("error counts: writeback %0d, control %0d", wb_errors, ctrl_errors);
        if (wb_errors + ctrl_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
